/* source/pcs_pkg.sv */
`default_nettype none

package pcs_pkg;

    // Block geometry
    localparam int pcs_block_width = 64;
    localparam int pcs_header_width = 2;
    localparam int pcs_block_bytes = 8;

    // Sync header codes, 00 and 11 are never legal
    localparam logic [pcs_header_width-1:0] pcs_hdr_data = 2'b01;
    localparam logic [pcs_header_width-1:0] pcs_hdr_ctrl = 2'b10;

    // Self-synchronous scrambler, x^58 + x^39 + 1
    localparam int pcs_scr_state_width = 58;
    localparam logic [pcs_scr_state_width-1:0] pcs_scr_reset_state = '1;
    // History taps, bit 0 holds the most recent scrambled bit
    localparam int pcs_scr_tap_near = 38;
    localparam int pcs_scr_tap_far = 57;

    // Control block type field
    localparam logic [7:0] pcs_type_idle = 8'h1E;
    localparam logic [7:0] pcs_type_start = 8'h78;

    // Terminate codes, suffix is the number of data bytes before the end
    localparam logic [7:0] pcs_type_term0 = 8'h87;
    localparam logic [7:0] pcs_type_term1 = 8'h99;
    localparam logic [7:0] pcs_type_term2 = 8'hAA;
    localparam logic [7:0] pcs_type_term3 = 8'hB4;
    localparam logic [7:0] pcs_type_term4 = 8'hCC;
    localparam logic [7:0] pcs_type_term5 = 8'hD2;
    localparam logic [7:0] pcs_type_term6 = 8'hE1;
    localparam logic [7:0] pcs_type_term7 = 8'hFF;

    // Valid byte count of one stream beat, 0 to 8
    typedef logic [3:0] pcs_keep_t;

    // Control view, type code sits in the first octet on the wire
    typedef struct packed {
        logic [55:0] rest;
        logic [7:0]  block_type;
    } pcs_ctrl_view_t;

    // One 64-bit payload, read as octets or as a control block
    typedef union packed {
        logic [pcs_block_bytes-1:0][7:0] octets;
        pcs_ctrl_view_t                  ctrl;
    } pcs_block_t;

endpackage

`default_nettype wire

/* source/pcs_scrambler.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_scrambler
    import pcs_pkg::*;
(
    input  wire                         clk_gtx_tx,
    input  wire                         i_rst_n,

    input  wire [pcs_block_width-1:0]   i_block,
    input  wire [pcs_header_width-1:0]  i_header,
    input  wire                         i_valid,

    output logic [pcs_block_width-1:0]  o_block,
    output logic [pcs_header_width-1:0] o_header,
    output logic                        o_valid
);

    logic [pcs_scr_state_width-1:0] scr_state;
    logic [pcs_scr_state_width-1:0] scr_state_next;
    logic [pcs_block_width-1:0]     scr_block;

    // Bit serial scramble, LSB first as on the wire
    always_comb begin
        scr_state_next = scr_state;
        for (int i = 0; i < pcs_block_width; i++) begin
            scr_block[i] = i_block[i] ^ scr_state_next[pcs_scr_tap_near]
                ^ scr_state_next[pcs_scr_tap_far];
            // Feedback comes from the scrambled output
            scr_state_next = {scr_state_next[pcs_scr_state_width-2:0], scr_block[i]};
        end
    end

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scr_state <= pcs_scr_reset_state;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                scr_state <= scr_state_next;
            end
        end
    end

    // Header goes out untouched
    always_ff @(posedge clk_gtx_tx) begin
        if (i_valid) begin
            o_block <= scr_block;
            o_header <= i_header;
        end
    end

endmodule

`default_nettype wire

/* source/pcs_descrambler.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_descrambler
    import pcs_pkg::*;
(
    input  wire                         clk_gtx_tx,
    input  wire                         i_rst_n,

    // Scrambled block straight from the transceiver
    input  wire [pcs_block_width-1:0]   i_block,
    input  wire [pcs_header_width-1:0]  i_header,
    input  wire                         i_valid,

    output logic [pcs_block_width-1:0]  o_block,
    output logic [pcs_header_width-1:0] o_header,
    output logic                        o_valid
);

    logic [pcs_scr_state_width-1:0] dscr_state;
    logic [pcs_scr_state_width-1:0] dscr_state_next;
    logic [pcs_block_width-1:0]     dscr_block;

    // Same taps as the transmitter
    always_comb begin
        dscr_state_next = dscr_state;
        for (int i = 0; i < pcs_block_width; i++) begin
            dscr_block[i] = i_block[i] ^ dscr_state_next[pcs_scr_tap_near]
                ^ dscr_state_next[pcs_scr_tap_far];
            // History takes the line bits, so any start state
            // flushes out after 58 bits
            dscr_state_next = {dscr_state_next[pcs_scr_state_width-2:0], i_block[i]};
        end
    end

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            dscr_state <= pcs_scr_reset_state;
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                dscr_state <= dscr_state_next;
            end
        end
    end

    // Header delayed to stay aligned with its payload
    always_ff @(posedge clk_gtx_tx) begin
        if (i_valid) begin
            o_block <= dscr_block;
            o_header <= i_header;
        end
    end

endmodule

`default_nettype wire

/* source/pcs_block_lock.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_block_lock
    import pcs_pkg::*;
#(
    parameter int LOCK_COUNT = 64,
    parameter int BAD_HEADER_LIMIT = 16
) (
    input  wire                        clk_gtx_tx,
    input  wire                        i_rst_n,

    input  wire [pcs_header_width-1:0] i_header,
    input  wire                        i_valid,

    output logic                       o_block_lock,
    output logic                       o_rx_slip
);

    localparam int CNT_W = $clog2(LOCK_COUNT + 1);
    localparam int BAD_W = $clog2(BAD_HEADER_LIMIT + 1);

    logic             hdr_ok;
    logic [CNT_W-1:0] sh_cnt;
    logic [BAD_W-1:0] bad_cnt;

    always_comb hdr_ok = (i_header == pcs_hdr_data) || (i_header == pcs_hdr_ctrl);

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_block_lock <= 1'b0;
            o_rx_slip <= 1'b0;
            sh_cnt <= '0;
            bad_cnt <= '0;
        end else begin
            o_rx_slip <= 1'b0;
            if (i_valid) begin
                if (!o_block_lock) begin
                    // Hunting for the header boundary
                    if (hdr_ok) begin
                        if (sh_cnt == CNT_W'(LOCK_COUNT - 1)) begin
                            o_block_lock <= 1'b1;
                            sh_cnt <= '0;
                            bad_cnt <= '0;
                        end else begin
                            sh_cnt <= sh_cnt + 1'b1;
                        end
                    end else begin
                        sh_cnt <= '0;
                        // Skip one cycle between slips so the
                        // transceiver sees separate pulses
                        o_rx_slip <= !o_rx_slip;
                    end
                end else begin
                    // Locked, watch bad headers per window
                    if (!hdr_ok && bad_cnt == BAD_W'(BAD_HEADER_LIMIT - 1)) begin
                        o_block_lock <= 1'b0;
                        sh_cnt <= '0;
                        bad_cnt <= '0;
                    end else if (sh_cnt == CNT_W'(LOCK_COUNT - 1)) begin
                        sh_cnt <= '0;
                        bad_cnt <= '0;
                    end else begin
                        sh_cnt <= sh_cnt + 1'b1;
                        bad_cnt <= bad_cnt + BAD_W'(!hdr_ok);
                    end
                end
            end
        end
    end

    // Slip is only ever requested while hunting
    slip_only_unlocked: assert property (
        @(posedge clk_gtx_tx) disable iff (!i_rst_n)
        !(o_rx_slip && o_block_lock)
    );

    // Transceiver slips once per pulse, so never hold it
    slip_single_cycle: assert property (
        @(posedge clk_gtx_tx) disable iff (!i_rst_n)
        o_rx_slip |=> !o_rx_slip
    );

endmodule

`default_nettype wire

/* source/pcs_rx_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_decoder
    import pcs_pkg::*;
(
    input  wire                        clk_gtx_tx,
    input  wire                        i_rst_n,

    input  pcs_block_t                 i_block,
    input  wire [pcs_header_width-1:0] i_header,
    input  wire                        i_valid,
    input  wire                        i_block_lock,

    // Ethernet stream out
    output pcs_block_t                 o_data,
    output pcs_keep_t                  o_keep,
    output logic                       o_valid,
    output logic                       o_last,
    output logic                       o_abort
);

    logic       in_frame;
    logic [7:0] block_type;
    logic       is_term;
    pcs_keep_t  term_bytes;
    pcs_block_t term_data;

    always_comb block_type = i_block.ctrl.block_type;

    // Terminate code gives the count of trailing data bytes
    always_comb begin
        is_term = 1'b1;
        term_bytes = '0;
        case (block_type)
            pcs_type_term0: term_bytes = 4'd0;
            pcs_type_term1: term_bytes = 4'd1;
            pcs_type_term2: term_bytes = 4'd2;
            pcs_type_term3: term_bytes = 4'd3;
            pcs_type_term4: term_bytes = 4'd4;
            pcs_type_term5: term_bytes = 4'd5;
            pcs_type_term6: term_bytes = 4'd6;
            pcs_type_term7: term_bytes = 4'd7;
            default: is_term = 1'b0;
        endcase
    end

    // Drop the type octet, data moves down to octet 0
    always_comb begin
        term_data = '0;
        for (int k = 0; k < pcs_block_bytes - 1; k++) begin
            term_data.octets[k] = i_block.octets[k+1];
        end
    end

    always_ff @(posedge clk_gtx_tx or negedge i_rst_n) begin
        if (!i_rst_n) begin
            in_frame <= 1'b0;
            o_valid <= 1'b0;
            o_last <= 1'b0;
            o_abort <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            o_last <= 1'b0;
            o_abort <= 1'b0;
            if (in_frame && !i_block_lock) begin
                // Lock lost mid-frame
                in_frame <= 1'b0;
                o_valid <= 1'b1;
                o_abort <= 1'b1;
            end else if (i_valid && i_block_lock) begin
                if (i_header == pcs_hdr_data) begin
                    o_valid <= in_frame;
                end else if (i_header == pcs_hdr_ctrl && block_type == pcs_type_start) begin
                    // Preamble only, no beat
                    in_frame <= 1'b1;
                end else if (i_header == pcs_hdr_ctrl && is_term) begin
                    in_frame <= 1'b0;
                    o_valid <= in_frame;
                    o_last <= in_frame;
                end else if (i_header == pcs_hdr_ctrl && block_type == pcs_type_idle) begin
                    // Inter-frame fill
                end else begin
                    // Bad header or unknown control type
                    in_frame <= 1'b0;
                    o_valid <= in_frame;
                    o_abort <= in_frame;
                end
            end
        end
    end

    // Payload side, keep is 0 for abort beats
    always_ff @(posedge clk_gtx_tx) begin
        if (i_header == pcs_hdr_ctrl && is_term) begin
            o_data <= term_data;
            o_keep <= term_bytes;
        end else if (i_header == pcs_hdr_data && i_block_lock) begin
            o_data <= i_block;
            o_keep <= pcs_keep_t'(pcs_block_bytes);
        end else begin
            o_data <= i_block;
            o_keep <= '0;
        end
    end

    keep_in_range: assert property (
        @(posedge clk_gtx_tx) disable iff (!i_rst_n)
        o_valid |-> (o_keep <= pcs_keep_t'(pcs_block_bytes))
    );

    last_with_valid: assert property (
        @(posedge clk_gtx_tx) disable iff (!i_rst_n)
        o_last |-> o_valid
    );

    abort_with_valid: assert property (
        @(posedge clk_gtx_tx) disable iff (!i_rst_n)
        o_abort |-> o_valid
    );

endmodule

`default_nettype wire

/* source/pcs_lane_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_lane_top
    import pcs_pkg::*;
#(
    parameter int LOCK_COUNT = 64,
    parameter int BAD_HEADER_LIMIT = 16
) (
    input  wire                         clk_gtx_tx,
    input  wire                         i_rst_n,

    // Transmit blocks in, scrambled blocks to the transceiver
    input  pcs_block_t                  i_tx_block,
    input  wire [pcs_header_width-1:0]  i_tx_header,
    input  wire                         i_tx_valid,
    output pcs_block_t                  o_tx_block,
    output logic [pcs_header_width-1:0] o_tx_header,
    output logic                        o_tx_valid,

    // Receive blocks from the transceiver
    input  pcs_block_t                  i_rx_block,
    input  wire [pcs_header_width-1:0]  i_rx_header,
    input  wire                         i_rx_valid,
    output logic                        o_rx_slip,
    output logic                        o_block_lock,

    // Ethernet stream
    output pcs_block_t                  o_rx_data,
    output pcs_keep_t                   o_rx_keep,
    output logic                        o_rx_valid,
    output logic                        o_rx_last,
    output logic                        o_rx_abort
);

    logic [pcs_block_width-1:0]  d_block;
    logic [pcs_header_width-1:0] d_header;
    logic                        d_valid;

    pcs_scrambler pcs_scrambler_u (
        .clk_gtx_tx(clk_gtx_tx),
        .i_rst_n(i_rst_n),
        .i_block(i_tx_block),
        .i_header(i_tx_header),
        .i_valid(i_tx_valid),
        .o_block(o_tx_block),
        .o_header(o_tx_header),
        .o_valid(o_tx_valid)
    );

    pcs_descrambler pcs_descrambler_u (
        .clk_gtx_tx(clk_gtx_tx),
        .i_rst_n(i_rst_n),
        .i_block(i_rx_block),
        .i_header(i_rx_header),
        .i_valid(i_rx_valid),
        .o_block(d_block),
        .o_header(d_header),
        .o_valid(d_valid)
    );

    // Lock works on the raw headers, one cycle ahead of the payload
    pcs_block_lock #(
        .LOCK_COUNT(LOCK_COUNT),
        .BAD_HEADER_LIMIT(BAD_HEADER_LIMIT))
    pcs_block_lock_u (
        .clk_gtx_tx(clk_gtx_tx),
        .i_rst_n(i_rst_n),
        .i_header(i_rx_header),
        .i_valid(i_rx_valid),
        .o_block_lock(o_block_lock),
        .o_rx_slip(o_rx_slip)
    );

    pcs_rx_decoder pcs_rx_decoder_u (
        .clk_gtx_tx(clk_gtx_tx),
        .i_rst_n(i_rst_n),
        .i_block(d_block),
        .i_header(d_header),
        .i_valid(d_valid),
        .i_block_lock(o_block_lock),
        .o_data(o_rx_data),
        .o_keep(o_rx_keep),
        .o_valid(o_rx_valid),
        .o_last(o_rx_last),
        .o_abort(o_rx_abort)
    );

endmodule

`default_nettype wire

/* testbench/tb_pcs_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pcs_lane
    import pcs_pkg::*;
();

    localparam int lock_count = 64;
    localparam int bad_header_limit = 16;
    localparam int slip_target = 3;
    // Tests take well under 2000 cycles, keep a wide margin
    localparam int timeout_cycles = 20000;
    localparam logic [63:0] idle_block = {56'h0, pcs_type_idle};

    logic       clk_gtx_tx;
    logic       i_rst_n;
    pcs_block_t i_tx_block;
    logic [1:0] i_tx_header;
    logic       i_tx_valid;
    pcs_block_t o_tx_block;
    logic [1:0] o_tx_header;
    logic       o_tx_valid;
    pcs_block_t i_rx_block;
    logic [1:0] i_rx_header;
    logic       i_rx_valid;
    logic       o_rx_slip;
    logic       o_block_lock;
    pcs_block_t o_rx_data;
    pcs_keep_t  o_rx_keep;
    logic       o_rx_valid;
    logic       o_rx_last;
    logic       o_rx_abort;

    int cycle_cnt = 0;
    int tx_errors = 0;
    int rx_errors = 0;
    int lock_errors = 0;
    int slip_total = 0;
    int lock_rises = 0;
    int lock_falls = 0;
    int rise_cycle = 0;
    int fall_cycle = 0;
    int good_cycle = 0;
    int win_pos = 0;
    logic lock_prev = 1'b0;

    logic [15:0] lfsr_state = 16'd14;
    logic [7:0]  frame_bytes [0:39];
    // Beat layout is abort, last, keep, data
    logic [69:0] exp_beats [$];

    logic        tx_pending = 1'b0;
    logic [63:0] exp_tx_block;
    logic [1:0]  exp_tx_header;

    pcs_lane_top #(
        .LOCK_COUNT(lock_count),
        .BAD_HEADER_LIMIT(bad_header_limit))
    dut_i (
        .clk_gtx_tx(clk_gtx_tx),
        .i_rst_n(i_rst_n),
        .i_tx_block(i_tx_block),
        .i_tx_header(i_tx_header),
        .i_tx_valid(i_tx_valid),
        .o_tx_block(o_tx_block),
        .o_tx_header(o_tx_header),
        .o_tx_valid(o_tx_valid),
        .i_rx_block(i_rx_block),
        .i_rx_header(i_rx_header),
        .i_rx_valid(i_rx_valid),
        .o_rx_slip(o_rx_slip),
        .o_block_lock(o_block_lock),
        .o_rx_data(o_rx_data),
        .o_rx_keep(o_rx_keep),
        .o_rx_valid(o_rx_valid),
        .o_rx_last(o_rx_last),
        .o_rx_abort(o_rx_abort)
    );

    initial begin
        clk_gtx_tx = 1'b0;
        forever #4 clk_gtx_tx = ~clk_gtx_tx;
    end

    always @(posedge clk_gtx_tx) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_state[15]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Line bits 0..57 are history, oldest first, then the 64 new bits
    function automatic logic [121:0] scramble_ref(input logic [57:0] hist,
                                                  input logic [63:0] data);
        logic [121:0] line;
        line = '0;
        line[57:0] = hist;
        for (int i = 0; i < 64; i++) begin
            line[58 + i] = data[i] ^ line[58 + i - 39] ^ line[58 + i - 58];
        end
        return line;
    endfunction

    function automatic logic [7:0] term_code(input int rem);
        case (rem)
            0: return pcs_type_term0;
            1: return pcs_type_term1;
            2: return pcs_type_term2;
            3: return pcs_type_term3;
            4: return pcs_type_term4;
            5: return pcs_type_term5;
            6: return pcs_type_term6;
            default: return pcs_type_term7;
        endcase
    endfunction

    // First byte goes in octet 0
    function automatic logic [63:0] data_word(input int base);
        logic [63:0] w;
        for (int k = 0; k < 8; k++) begin
            w[8*k +: 8] = frame_bytes[base + k];
        end
        return w;
    endfunction

    // Expected beats of a frame that ends normally
    function automatic void frame_to_beats(input int len);
        logic [63:0] d;
        d = '0;
        for (int b = 0; b < len / 8; b++) begin
            exp_beats.push_back({1'b0, 1'b0, 4'd8, data_word(8 * b)});
        end
        for (int k = 0; k < len % 8; k++) begin
            d[8*k +: 8] = frame_bytes[8 * (len / 8) + k];
        end
        exp_beats.push_back({1'b0, 1'b1, 4'(len % 8), d});
    endfunction

    task automatic send_block(input logic [1:0] hdr, input logic [63:0] blk);
        @(posedge clk_gtx_tx);
        i_tx_header <= hdr;
        i_tx_block <= blk;
        i_tx_valid <= 1'b1;
    endtask

    task automatic send_idles(input int n);
        for (int i = 0; i < n; i++) begin
            send_block(pcs_hdr_ctrl, idle_block);
        end
    endtask

    task automatic fill_bytes(input int n);
        logic [31:0] rnd;
        for (int k = 0; k < n; k++) begin
            take_bits(8, rnd);
            frame_bytes[k] = rnd[7:0];
        end
    endtask

    task automatic send_frame(input int len);
        logic [63:0] blk;
        send_block(pcs_hdr_ctrl, {8'hD5, {6{8'h55}}, pcs_type_start});
        for (int b = 0; b < len / 8; b++) begin
            send_block(pcs_hdr_data, data_word(8 * b));
        end
        blk = '0;
        blk[7:0] = term_code(len % 8);
        for (int k = 0; k < len % 8; k++) begin
            blk[8*(k+1) +: 8] = frame_bytes[8 * (len / 8) + k];
        end
        send_block(pcs_hdr_ctrl, blk);
    endtask

    // Random frame of 1 to 40 bytes followed by 1 to 4 idles
    task automatic run_frame();
        logic [31:0] rnd;
        int len;
        take_bits(6, rnd);
        len = int'(rnd % 32'd40) + 1;
        fill_bytes(len);
        frame_to_beats(len);
        send_frame(len);
        take_bits(2, rnd);
        send_idles(int'(rnd) + 1);
    endtask

    // Loopback channel, holds the header at 00 until enough slips
    initial begin
        int slips_seen;
        logic hunting;
        slips_seen = 0;
        hunting = 1'b1;
        i_rx_block <= '0;
        i_rx_header <= 2'b00;
        i_rx_valid <= 1'b0;
        forever begin
            @(posedge clk_gtx_tx);
            if (o_rx_slip) begin
                slips_seen = slips_seen + 1;
            end
            i_rx_block <= o_tx_block;
            i_rx_valid <= o_tx_valid;
            if (slips_seen < slip_target) begin
                i_rx_header <= 2'b00;
            end else begin
                if (hunting) begin
                    good_cycle <= cycle_cnt;
                    hunting = 1'b0;
                end
                i_rx_header <= o_tx_header;
            end
        end
    end

    // Lock edges, slips, and position inside the lock window
    always @(posedge clk_gtx_tx) begin
        lock_prev <= o_block_lock;
        if (o_rx_slip) begin
            slip_total <= slip_total + 1;
        end
        if (o_block_lock && !lock_prev) begin
            lock_rises <= lock_rises + 1;
            rise_cycle <= cycle_cnt;
        end
        if (!o_block_lock && lock_prev) begin
            lock_falls <= lock_falls + 1;
            fall_cycle <= cycle_cnt;
        end
        if (!o_block_lock) begin
            win_pos <= 0;
        end else if (i_rx_valid) begin
            win_pos <= (win_pos + 1) % lock_count;
        end
    end

    always @(posedge clk_gtx_tx) begin : tx_compare
        logic [121:0] line;
        logic [57:0]  ref_state;
        if (!i_rst_n) begin
            ref_state = '1;
            tx_pending <= 1'b0;
        end else begin
            if (o_tx_valid != tx_pending) begin
                $display("[FAIL] %0t: o_tx_valid %b, expected %b", $time, o_tx_valid,
                    tx_pending);
                tx_errors = tx_errors + 1;
            end
            if (tx_pending && (o_tx_block != exp_tx_block || o_tx_header != exp_tx_header)) begin
                $display("[FAIL] %0t: tx %h/%b, expected %h/%b", $time, o_tx_block,
                    o_tx_header, exp_tx_block, exp_tx_header);
                tx_errors = tx_errors + 1;
            end
            tx_pending <= i_tx_valid;
            if (i_tx_valid) begin
                line = scramble_ref(ref_state, i_tx_block);
                ref_state = line[121:64];
                exp_tx_block <= line[121:58];
                exp_tx_header <= i_tx_header;
            end
        end
    end

    always @(posedge clk_gtx_tx) begin : rx_compare
        logic [69:0] beat;
        logic [63:0] mask;
        if (i_rst_n && o_rx_valid) begin
            if (exp_beats.size() == 0) begin
                $display("Stream beat at %0t arrived with no beat expected", $time);
                rx_errors = rx_errors + 1;
            end else begin
                beat = exp_beats.pop_front();
                mask = '0;
                for (int k = 0; k < 8; k++) begin
                    if (k < int'(beat[67:64])) begin
                        mask[8*k +: 8] = 8'hFF;
                    end
                end
                if (o_rx_abort != beat[69] || o_rx_last != beat[68]) begin
                    $display("[FAIL] %0t: abort/last %b%b, expected %b%b", $time,
                        o_rx_abort, o_rx_last, beat[69], beat[68]);
                    rx_errors = rx_errors + 1;
                end else if (!beat[69] && o_rx_keep != beat[67:64]) begin
                    $display("[FAIL] %0t: keep %0d, expected %0d", $time, o_rx_keep,
                        beat[67:64]);
                    rx_errors = rx_errors + 1;
                end else if (!beat[69] && (o_rx_data & mask) != (beat[63:0] & mask)) begin
                    $display("[FAIL] %0t: data %h, expected %h", $time, o_rx_data & mask,
                        beat[63:0] & mask);
                    rx_errors = rx_errors + 1;
                end
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        logic        aligned;
        i_rst_n <= 1'b0;
        i_tx_block <= idle_block;
        i_tx_header <= pcs_hdr_ctrl;
        i_tx_valid <= 1'b0;
        repeat (16) @(posedge clk_gtx_tx);
        i_rst_n <= 1'b1;
        // Idles flow from here on whenever no block is sent
        send_block(pcs_hdr_ctrl, idle_block);

        // Slips while hunting, then lock
        while (lock_rises == 0) @(posedge clk_gtx_tx);
        if (slip_total != slip_target) begin
            $display("[FAIL] %0t: %0d slips before lock, expected %0d", $time, slip_total,
                slip_target);
            lock_errors = lock_errors + 1;
        end
        if (rise_cycle - good_cycle != 65) begin
            $display("[FAIL] %0t: lock %0d cycles after first good header, expected 65",
                $time, rise_cycle - good_cycle);
            lock_errors = lock_errors + 1;
        end

        for (int f = 0; f < 40; f++) begin
            run_frame();
        end

        // Unknown control type mid-frame
        fill_bytes(16);
        exp_beats.push_back({1'b0, 1'b0, 4'd8, data_word(0)});
        exp_beats.push_back({1'b0, 1'b0, 4'd8, data_word(8)});
        exp_beats.push_back({1'b1, 1'b0, 4'd0, 64'h0});
        send_block(pcs_hdr_ctrl, {8'hD5, {6{8'h55}}, pcs_type_start});
        send_block(pcs_hdr_data, data_word(0));
        send_block(pcs_hdr_data, data_word(8));
        take_bits(32, rnd);
        send_block(pcs_hdr_ctrl, {24'h0, rnd, 8'h55});
        send_idles(2);
        run_frame();

        // Bad headers mid-frame, placed well inside one lock window
        send_block(pcs_hdr_ctrl, {8'hD5, {6{8'h55}}, pcs_type_start});
        aligned = 1'b0;
        while (!aligned) begin
            fill_bytes(8);
            exp_beats.push_back({1'b0, 1'b0, 4'd8, data_word(0)});
            send_block(pcs_hdr_data, data_word(0));
            aligned = (win_pos >= 8 && win_pos <= 32);
        end
        exp_beats.push_back({1'b1, 1'b0, 4'd0, 64'h0});
        for (int i = 0; i < bad_header_limit; i++) begin
            take_bits(32, rnd);
            send_block(2'b00, {rnd, rnd});
        end
        send_block(pcs_hdr_ctrl, idle_block);
        while (lock_rises < 2) @(posedge clk_gtx_tx);
        if (lock_falls != 1 || rise_cycle - fall_cycle != lock_count) begin
            $display("[FAIL] %0t: %0d lock drops, relock after %0d cycles, expected 1 and %0d",
                $time, lock_falls, rise_cycle - fall_cycle, lock_count);
            lock_errors = lock_errors + 1;
        end
        run_frame();

        while (exp_beats.size() != 0) @(posedge clk_gtx_tx);
        repeat (8) @(posedge clk_gtx_tx);
        if (slip_total != slip_target) begin
            $display("Slip was requested again after the first lock, %0d slips in total",
                slip_total);
            lock_errors = lock_errors + 1;
        end

        $display("Errors: tx %0d, rx %0d, lock %0d", tx_errors, rx_errors, lock_errors);
        if (tx_errors + rx_errors + lock_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk_gtx_tx);
        $display("Run did not finish within %0d cycles", timeout_cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/pcs_pkg.sv
source/pcs_scrambler.sv
source/pcs_descrambler.sv
source/pcs_block_lock.sv
source/pcs_rx_decoder.sv
source/pcs_lane_top.sv
testbench/tb_pcs_lane.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_pcs_lane
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
